// File: axi_lite_mux_defs.svh
// AXI4-Lite write mux defines for port count, outstanding depth and bus widths
`ifndef AXI_LITE_MUX_DEFS_SVH
`define AXI_LITE_MUX_DEFS_SVH

// Requesting ports sharing the downstream port
`define AXI_LITE_MUX_NUM_PORTS 4

// Depth of each select FIFO
// Also caps the writes in flight
`define AXI_LITE_MUX_MAX_TRANS 4

// Bus widths
`define AXI_LITE_MUX_ADDR_W 32
`define AXI_LITE_MUX_DATA_W 32

// One strobe bit per data byte
`define AXI_LITE_MUX_STRB_W (`AXI_LITE_MUX_DATA_W / 8)

`endif

// File: axi_lite_mux_pkg.sv
// AXI4-Lite write mux types for channel payloads, port bundles and port select
`include "axi_lite_mux_defs.svh"

package axi_lite_mux_pkg;

  // Index of one requesting port
  typedef logic [$clog2(`AXI_LITE_MUX_NUM_PORTS)-1:0] port_sel_t;

  // ------------------------------
  // Channel payloads
  // ------------------------------
  // AW, address plus protection
  typedef struct packed {
    logic [`AXI_LITE_MUX_ADDR_W-1:0] addr;
    logic [2:0]                      prot;
  } aw_chan_t;

  // W, data plus byte strobes
  typedef struct packed {
    logic [`AXI_LITE_MUX_DATA_W-1:0] data;
    logic [`AXI_LITE_MUX_STRB_W-1:0] strb;
  } w_chan_t;

  // B, response code only
  typedef struct packed {
    logic [1:0] resp;
  } b_chan_t;

  // ------------------------------
  // Per-port bundles
  // ------------------------------
  // Everything a requester drives
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
  } wr_req_t;

  // Everything a requester sees back
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
  } wr_rsp_t;

endpackage

// File: rr_arbiter.sv
// Round-robin AW arbiter with lock-in that keeps its pick until the transfer
`include "axi_lite_mux_defs.svh"

module rr_arbiter (
  input  logic                                                     clk_i,
  input  logic                                                     rst_i,
  input  logic [`AXI_LITE_MUX_NUM_PORTS-1:0]                       req_i,
  input  axi_lite_mux_pkg::aw_chan_t [`AXI_LITE_MUX_NUM_PORTS-1:0] data_i,
  output logic [`AXI_LITE_MUX_NUM_PORTS-1:0]                       gnt_o,
  output logic                                                     valid_o,
  input  logic                                                     ready_i,
  output axi_lite_mux_pkg::aw_chan_t                               data_o,
  output axi_lite_mux_pkg::port_sel_t                              sel_o
);

  localparam int unsigned num_ports = `AXI_LITE_MUX_NUM_PORTS;

  // Rotating priority pointer
  axi_lite_mux_pkg::port_sel_t rr_ptr_q;
  // Pick held across a stalled handshake
  logic                        lock_q;
  axi_lite_mux_pkg::port_sel_t lock_sel_q;
  // Fresh search result
  axi_lite_mux_pkg::port_sel_t rr_sel;
  logic                        rr_found;
  logic                        xfer;

  // First requester at or after the pointer, wrapping around
  always_comb begin
    rr_sel   = rr_ptr_q;
    rr_found = 1'b0;
    for (int k = 0; k < num_ports; k++) begin
      if (!rr_found && req_i[(int'(rr_ptr_q) + k) % num_ports]) begin
        rr_sel   = axi_lite_mux_pkg::port_sel_t'((int'(rr_ptr_q) + k) % num_ports);
        rr_found = 1'b1;
      end
    end
  end

  // Locked pick overrides the search
  assign sel_o   = lock_q ? lock_sel_q : rr_sel;
  assign valid_o = lock_q ? req_i[lock_sel_q] : rr_found;
  assign data_o  = data_i[sel_o];
  assign xfer    = valid_o & ready_i;

  // Grant doubles as the port's aw_ready
  // High only in the transfer cycle
  always_comb begin
    gnt_o        = '0;
    gnt_o[sel_o] = xfer;
  end

  // ------------------------------
  // Lock and pointer state
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_ptr_q   <= '0;
      lock_q     <= 1'b0;
      lock_sel_q <= '0;
    end else begin
      // Stall holds the decision
      lock_q <= valid_o & ~ready_i;
      if (valid_o && !ready_i) begin
        lock_sel_q <= sel_o;
      end
      // Winner drops to lowest priority
      if (xfer) begin
        rr_ptr_q <= axi_lite_mux_pkg::port_sel_t'((int'(sel_o) + 1) % num_ports);
      end
    end
  end

endmodule

// File: sel_fifo.sv
// Select FIFO holding the port index of each write in flight, with full and empty flags
`include "axi_lite_mux_defs.svh"

module sel_fifo (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        push_i,
  input  logic                        pop_i,
  input  axi_lite_mux_pkg::port_sel_t data_i,
  output axi_lite_mux_pkg::port_sel_t data_o,
  output logic                        full_o,
  output logic                        empty_o
);

  localparam int unsigned depth = `AXI_LITE_MUX_MAX_TRANS;
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  // Circular storage
  axi_lite_mux_pkg::port_sel_t mem_q [depth];
  logic [ptr_w-1:0]            wr_ptr_q;
  logic [ptr_w-1:0]            rd_ptr_q;
  // Fill level, source of both flags
  logic [cnt_w-1:0]            count_q;
  logic                        do_push;
  logic                        do_pop;

  assign full_o  = (count_q == cnt_w'(depth));
  assign empty_o = (count_q == '0);

  // Push on full and pop on empty are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Head is read straight from storage
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // ------------------------------
  // Pointers and count
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the level alone
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: spill_reg.sv
// Two-entry valid/ready spill register that breaks the ready path for any payload type
module spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Output slot, always the one presented
  logic out_full_q;
  T     out_data_q;
  // Spill slot, catches an item while the output stalls
  logic spill_full_q;
  T     spill_data_q;

  logic in_xfer;
  logic out_xfer;
  logic out_load;

  // Ready from registered state only
  assign ready_o = ~spill_full_q;
  assign valid_o = out_full_q;
  assign data_o  = out_data_q;

  assign in_xfer  = valid_i & ready_o;
  assign out_xfer = out_full_q & ready_i;

  // Output slot empty or draining this cycle
  assign out_load = ~out_full_q | ready_i;

  // ------------------------------
  // Slot occupancy
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_full_q   <= 1'b0;
      spill_full_q <= 1'b0;
    end else begin
      // Spill slot refills the output first, keeping order
      if (out_load) begin
        out_full_q <= spill_full_q | in_xfer;
      end
      if (spill_full_q) begin
        spill_full_q <= ~out_xfer;
      end else begin
        // New item with the output stuck goes aside
        spill_full_q <= in_xfer & ~out_load;
      end
    end
  end

  // ------------------------------
  // Payload
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (out_load && (spill_full_q || in_xfer)) begin
      out_data_q <= spill_full_q ? spill_data_q : data_i;
    end
    if (!spill_full_q && in_xfer && !out_load) begin
      spill_data_q <= data_i;
    end
  end

endmodule

// File: wr_route.sv
// Write router with AW lock, W steering and in-order B return over two select FIFOs
`include "axi_lite_mux_defs.svh"

module wr_route (
  input  logic                                                  clk_i,
  input  logic                                                  rst_i,
  // Arbiter decision
  input  logic                                                  arb_valid_i,
  output logic                                                  arb_ready_o,
  input  axi_lite_mux_pkg::port_sel_t                           arb_sel_i,
  // Toward the AW spill register
  output logic                                                  aw_valid_o,
  input  logic                                                  aw_ready_i,
  // Requesting ports
  input  axi_lite_mux_pkg::wr_req_t [`AXI_LITE_MUX_NUM_PORTS-1:0] port_req_i,
  output logic [`AXI_LITE_MUX_NUM_PORTS-1:0]                    port_w_ready_o,
  output logic [`AXI_LITE_MUX_NUM_PORTS-1:0]                    port_b_valid_o,
  // Toward the W spill register
  output logic                                                  w_valid_o,
  output axi_lite_mux_pkg::w_chan_t                             w_data_o,
  input  logic                                                  w_ready_i,
  // From the B spill register
  input  logic                                                  b_valid_i,
  output logic                                                  b_ready_o
);

  localparam int unsigned num_ports = `AXI_LITE_MUX_NUM_PORTS;

  // Set once a decision is in the W FIFO but AW is still stalled
  logic                        aw_lock_q;
  logic                        aw_lock_d;

  logic                        w_fifo_push;
  logic                        w_fifo_pop;
  logic                        w_fifo_full;
  logic                        w_fifo_empty;
  axi_lite_mux_pkg::port_sel_t w_sel;
  // W path open for the head port
  logic                        w_en;

  logic                        b_fifo_pop;
  logic                        b_fifo_full;
  logic                        b_fifo_empty;
  axi_lite_mux_pkg::port_sel_t b_sel;

  // ------------------------------
  // AW channel
  // ------------------------------
  always_comb begin
    aw_lock_d   = aw_lock_q;
    w_fifo_push = 1'b0;
    aw_valid_o  = 1'b0;
    arb_ready_o = 1'b0;
    if (aw_lock_q) begin
      // Already pushed, only finish the handshake
      aw_valid_o  = 1'b1;
      arb_ready_o = aw_ready_i;
      if (aw_ready_i) begin
        aw_lock_d = 1'b0;
      end
    end else if (arb_valid_i && !w_fifo_full) begin
      // New decision, record the port for W
      aw_valid_o  = 1'b1;
      w_fifo_push = 1'b1;
      arb_ready_o = aw_ready_i;
      aw_lock_d   = ~aw_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      aw_lock_q <= 1'b0;
    end else begin
      aw_lock_q <= aw_lock_d;
    end
  end

  sel_fifo u_w_sel_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (w_fifo_push),
    .pop_i   (w_fifo_pop),
    .data_i  (arb_sel_i),
    .data_o  (w_sel),
    .full_o  (w_fifo_full),
    .empty_o (w_fifo_empty)
  );

  // ------------------------------
  // W channel
  // ------------------------------
  // Needs a granted AW and room for the B return
  assign w_en       = ~w_fifo_empty & ~b_fifo_full;
  assign w_valid_o  = w_en & port_req_i[w_sel].w_valid;
  assign w_data_o   = w_en ? port_req_i[w_sel].w : '0;
  assign w_fifo_pop = w_valid_o & w_ready_i;

  // Each beat hands its port over to the B FIFO
  sel_fifo u_b_sel_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (w_fifo_pop),
    .pop_i   (b_fifo_pop),
    .data_i  (w_sel),
    .data_o  (b_sel),
    .full_o  (b_fifo_full),
    .empty_o (b_fifo_empty)
  );

  // ------------------------------
  // B channel
  // ------------------------------
  assign b_ready_o  = ~b_fifo_empty & port_req_i[b_sel].b_ready;
  assign b_fifo_pop = b_valid_i & b_ready_o;

  // Only the head port sees W ready or B valid
  for (genvar i = 0; i < num_ports; i++) begin : gen_port_ctrl
    assign port_w_ready_o[i] = w_ready_i & w_en &
                               (w_sel == axi_lite_mux_pkg::port_sel_t'(i));
    assign port_b_valid_o[i] = b_valid_i & ~b_fifo_empty &
                               (b_sel == axi_lite_mux_pkg::port_sel_t'(i));
  end

endmodule

// File: axi_lite_wr_mux.sv
// AXI4-Lite write multiplexer joining several requesting ports onto one downstream port
`include "axi_lite_mux_defs.svh"

module axi_lite_wr_mux (
  input  logic                                                  clk_i,
  input  logic                                                  rst_i,
  input  axi_lite_mux_pkg::wr_req_t [`AXI_LITE_MUX_NUM_PORTS-1:0] slv_reqs_i,
  output axi_lite_mux_pkg::wr_rsp_t [`AXI_LITE_MUX_NUM_PORTS-1:0] slv_rsps_o,
  output axi_lite_mux_pkg::wr_req_t                             mst_req_o,
  input  axi_lite_mux_pkg::wr_rsp_t                             mst_rsp_i
);

  localparam int unsigned num_ports = `AXI_LITE_MUX_NUM_PORTS;

  // Arbiter inputs unpacked from the port bundles
  logic [num_ports-1:0]                          aw_valids;
  axi_lite_mux_pkg::aw_chan_t [num_ports-1:0]    aw_chans;
  logic [num_ports-1:0]                          aw_gnts;
  // Arbiter decision
  logic                                          arb_valid;
  logic                                          arb_ready;
  axi_lite_mux_pkg::aw_chan_t                    arb_aw;
  axi_lite_mux_pkg::port_sel_t                   arb_sel;
  // Spill register upstream sides
  logic                                          aw_valid;
  logic                                          aw_ready;
  logic                                          w_valid;
  logic                                          w_ready;
  axi_lite_mux_pkg::w_chan_t                     w_data;
  logic                                          b_valid;
  logic                                          b_ready;
  axi_lite_mux_pkg::b_chan_t                     b_data;
  // Per-port handshakes from the router
  logic [num_ports-1:0]                          port_w_ready;
  logic [num_ports-1:0]                          port_b_valid;

  // B payload goes to every port, valid picks the owner
  for (genvar i = 0; i < num_ports; i++) begin : gen_ports
    assign aw_valids[i]           = slv_reqs_i[i].aw_valid;
    assign aw_chans[i]            = slv_reqs_i[i].aw;
    assign slv_rsps_o[i].aw_ready = aw_gnts[i];
    assign slv_rsps_o[i].w_ready  = port_w_ready[i];
    assign slv_rsps_o[i].b        = b_data;
    assign slv_rsps_o[i].b_valid  = port_b_valid[i];
  end

  rr_arbiter u_rr_arbiter (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (aw_valids),
    .data_i  (aw_chans),
    .gnt_o   (aw_gnts),
    .valid_o (arb_valid),
    .ready_i (arb_ready),
    .data_o  (arb_aw),
    .sel_o   (arb_sel)
  );

  wr_route u_wr_route (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .arb_valid_i    (arb_valid),
    .arb_ready_o    (arb_ready),
    .arb_sel_i      (arb_sel),
    .aw_valid_o     (aw_valid),
    .aw_ready_i     (aw_ready),
    .port_req_i     (slv_reqs_i),
    .port_w_ready_o (port_w_ready),
    .port_b_valid_o (port_b_valid),
    .w_valid_o      (w_valid),
    .w_data_o       (w_data),
    .w_ready_i      (w_ready),
    .b_valid_i      (b_valid),
    .b_ready_o      (b_ready)
  );

  // ------------------------------
  // Downstream spill registers
  // ------------------------------
  spill_reg #(
    .T (axi_lite_mux_pkg::aw_chan_t)
  ) u_aw_spill_reg (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (aw_valid),
    .ready_o (aw_ready),
    .data_i  (arb_aw),
    .valid_o (mst_req_o.aw_valid),
    .ready_i (mst_rsp_i.aw_ready),
    .data_o  (mst_req_o.aw)
  );

  spill_reg #(
    .T (axi_lite_mux_pkg::w_chan_t)
  ) u_w_spill_reg (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (w_valid),
    .ready_o (w_ready),
    .data_i  (w_data),
    .valid_o (mst_req_o.w_valid),
    .ready_i (mst_rsp_i.w_ready),
    .data_o  (mst_req_o.w)
  );

  // Response direction, downstream toward the ports
  spill_reg #(
    .T (axi_lite_mux_pkg::b_chan_t)
  ) u_b_spill_reg (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (mst_rsp_i.b_valid),
    .ready_o (mst_req_o.b_ready),
    .data_i  (mst_rsp_i.b),
    .valid_o (b_valid),
    .ready_i (b_ready),
    .data_o  (b_data)
  );

endmodule

// File: tb_clock.sv
// Testbench clock source, free running with a 40 time unit period
module tb_clock #(
  parameter int unsigned half_period = 20
) (
  output logic clk_o
);

  // Starts low, first rising edge after one half period
  initial begin
    clk_o = 1'b0;
    forever begin
      #(half_period) clk_o = ~clk_o;
    end
  end

endmodule

// File: axi_lite_wr_mux_assertions.sv
// Protocol checks on the write mux downstream channels and per-port W ready
`include "axi_lite_mux_defs.svh"

module axi_lite_wr_mux_assertions (
  input logic                                                  clk_i,
  input logic                                                  rst_i,
  input axi_lite_mux_pkg::wr_req_t                             mst_req_i,
  input axi_lite_mux_pkg::wr_rsp_t                             mst_rsp_i,
  input axi_lite_mux_pkg::wr_rsp_t [`AXI_LITE_MUX_NUM_PORTS-1:0] slv_rsps_i
);

  // Count of failed checks
  int unsigned error_count = 0;
  // W ready of every port side by side
  logic [`AXI_LITE_MUX_NUM_PORTS-1:0] w_readies;

  always_comb begin
    for (int i = 0; i < `AXI_LITE_MUX_NUM_PORTS; i++) begin
      w_readies[i] = slv_rsps_i[i].w_ready;
    end
  end

  // AW held with its payload until taken
  a_aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    mst_req_i.aw_valid && !mst_rsp_i.aw_ready |=>
      mst_req_i.aw_valid && $stable(mst_req_i.aw))
  else begin
    $error("Downstream AW dropped or changed before ready");
    error_count++;
  end

  // Same rule on W
  a_w_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    mst_req_i.w_valid && !mst_rsp_i.w_ready |=>
      mst_req_i.w_valid && $stable(mst_req_i.w))
  else begin
    $error("Downstream W dropped or changed before ready");
    error_count++;
  end

  // W steered to one port at most
  a_w_ready_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(w_readies))
  else begin
    $error("More than one port has w_ready high");
    error_count++;
  end

endmodule

bind axi_lite_wr_mux axi_lite_wr_mux_assertions u_wr_mux_assertions (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .mst_req_i  (mst_req_o),
  .mst_rsp_i  (mst_rsp_i),
  .slv_rsps_i (slv_rsps_o)
);

// File: axi_lite_wr_mux_tb.sv
// Testbench for the AXI4-Lite write mux, ports fed from a data file, random-ready slave
`include "axi_lite_mux_defs.svh"

module axi_lite_wr_mux_tb;

  localparam int num_ports   = `AXI_LITE_MUX_NUM_PORTS;
  localparam int num_writes  = 24;
  localparam int drive_delay = 4;
  localparam int max_cycles  = 5000;

  logic                                      clk;
  logic                                      rst;
  axi_lite_mux_pkg::wr_req_t [num_ports-1:0] slv_reqs;
  axi_lite_mux_pkg::wr_rsp_t [num_ports-1:0] slv_rsps;
  axi_lite_mux_pkg::wr_req_t                 mst_req;
  axi_lite_mux_pkg::wr_rsp_t                 mst_rsp;

  // Raw file words, five per write
  logic [31:0] stim_mem [0:num_writes*5-1];
  // Write table
  int          st_port [num_writes];
  logic [31:0] st_addr [num_writes];
  logic [31:0] st_data [num_writes];
  logic [3:0]  st_strb [num_writes];
  logic [1:0]  st_resp [num_writes];
  int          port_ids [num_ports][$];
  // Per port progress: offered AW, offered W, seen downstream
  int          aw_idx [num_ports];
  int          w_idx [num_ports];
  int          ds_idx [num_ports];
  logic        requests_on;
  // Slave side bookkeeping
  int                        aw_ids [$];
  axi_lite_mux_pkg::w_chan_t early_w [$];
  int                        b_pend [$];
  int                        b_expect [$];
  // Round robin tracking
  bit          rot_q [$];
  bit          all_busy;
  bit          granted_once;
  int          last_ds_port;
  int          done_cnt [num_writes];
  int          completed;
  logic [31:0] lfsr_q;

  tb_clock u_tb_clock (
    .clk_o (clk)
  );

  axi_lite_wr_mux u_axi_lite_wr_mux (
    .clk_i      (clk),
    .rst_i      (rst),
    .slv_reqs_i (slv_reqs),
    .slv_rsps_o (slv_rsps),
    .mst_req_o  (mst_req),
    .mst_rsp_i  (mst_rsp)
  );

  // Galois LFSR, one step per bit
  function automatic logic next_bit();
    logic lsb;
    lsb    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (lsb) begin
      lfsr_q = lfsr_q ^ 32'h80200003;
    end
    return lfsr_q[0];
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
    $display("TESTS FAILED");
    $fatal(1, "Value mismatch");
  endtask

  task automatic report_error(input string what);
    $display("Error at %0t: %s", $time, what);
    $display("TESTS FAILED");
    $fatal(1, "Check failed");
  endtask

  // ------------------------------
  // Data file and drive
  // ------------------------------
  task automatic load_writes();
    $readmemh("wr_mux_input.txt", stim_mem);
    for (int i = 0; i < num_writes; i++) begin
      // Port field must be legal and match the address top bits
      assert (stim_mem[i*5] < num_ports && stim_mem[i*5+1][31:30] === stim_mem[i*5][1:0])
        else report_error("bad port or address in the data file");
      st_port[i] = int'(stim_mem[i*5]);
      st_addr[i] = stim_mem[i*5+1];
      st_data[i] = stim_mem[i*5+2];
      st_strb[i] = stim_mem[i*5+3][3:0];
      st_resp[i] = stim_mem[i*5+4][1:0];
      port_ids[st_port[i]].push_back(i);
    end
  endtask

  task automatic drive_inputs();
    int id;
    for (int p = 0; p < num_ports; p++) begin
      slv_reqs[p] = '0;
      if (requests_on && aw_idx[p] < port_ids[p].size()) begin
        id                   = port_ids[p][aw_idx[p]];
        slv_reqs[p].aw_valid = 1'b1;
        slv_reqs[p].aw.addr  = st_addr[id];
        // Protection bits tag the write index
        slv_reqs[p].aw.prot  = 3'(id);
      end
      if (requests_on && w_idx[p] < port_ids[p].size()) begin
        id                  = port_ids[p][w_idx[p]];
        slv_reqs[p].w_valid = 1'b1;
        slv_reqs[p].w.data  = st_data[id];
        slv_reqs[p].w.strb  = st_strb[id];
      end
      slv_reqs[p].b_ready = requests_on & next_bit();
    end
    // Downstream slave
    mst_rsp          = '0;
    mst_rsp.aw_ready = next_bit();
    mst_rsp.w_ready  = next_bit();
    if (b_pend.size() > 0) begin
      mst_rsp.b_valid = 1'b1;
      mst_rsp.b.resp  = st_resp[b_pend[0]];
    end
  endtask

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic check_idle();
    assert (!mst_req.aw_valid) else report_value("mst_req_o.aw_valid", mst_req.aw_valid, 0);
    assert (!mst_req.w_valid) else report_value("mst_req_o.w_valid", mst_req.w_valid, 0);
    for (int i = 0; i < num_ports; i++) begin
      assert (!slv_rsps[i].aw_ready) else report_value("slv_rsps_o.aw_ready", 1, 0);
      assert (!slv_rsps[i].w_ready) else report_value("slv_rsps_o.w_ready", 1, 0);
      assert (!slv_rsps[i].b_valid) else report_value("slv_rsps_o.b_valid", 1, 0);
    end
  endtask

  // W beat against the oldest unmatched AW
  task automatic check_w(input int id, input axi_lite_mux_pkg::w_chan_t beat);
    assert (beat.data == st_data[id])
      else report_value("mst_req_o.w.data", beat.data, st_data[id]);
    assert (beat.strb == st_strb[id])
      else report_value("mst_req_o.w.strb", beat.strb, st_strb[id]);
    b_pend.push_back(id);
  endtask

  // Sampled at the falling edge, all handshakes settled
  task automatic sample_cycle();
    int id;
    int p;
    int busy_ports;
    int bv_count;
    assert (u_axi_lite_wr_mux.u_wr_mux_assertions.error_count == 0)
      else report_error("a bound protocol assertion failed");
    // Port B first, due items were queued in earlier cycles
    bv_count = 0;
    for (int i = 0; i < num_ports; i++) begin
      if (slv_rsps[i].b_valid) begin
        bv_count++;
        assert (b_expect.size() > 0) else report_error("b_valid at a port with no response due");
        id = b_expect[0];
        assert (st_port[id] == i) else report_value("slv_rsps_o.b_valid port", i, st_port[id]);
        assert (slv_rsps[i].b.resp == st_resp[id])
          else report_value("slv_rsps_o.b.resp", slv_rsps[i].b.resp, st_resp[id]);
        if (slv_reqs[i].b_ready) begin
          void'(b_expect.pop_front());
          assert (done_cnt[id] == 0) else report_error("a write completed twice");
          done_cnt[id]++;
          completed++;
        end
      end
    end
    assert (bv_count <= 1) else report_error("more than one port sees b_valid");
    if (mst_rsp.b_valid && mst_req.b_ready) begin
      b_expect.push_back(b_pend.pop_front());
    end
    // Downstream AW, address top bits name the port
    if (mst_req.aw_valid && mst_rsp.aw_ready) begin
      p = int'(mst_req.aw.addr[31:30]);
      assert (ds_idx[p] < port_ids[p].size())
        else report_error("extra AW at the downstream port");
      id = port_ids[p][ds_idx[p]];
      ds_idx[p]++;
      assert (mst_req.aw.addr == st_addr[id])
        else report_value("mst_req_o.aw.addr", mst_req.aw.addr, st_addr[id]);
      assert (mst_req.aw.prot == 3'(id))
        else report_value("mst_req_o.aw.prot", mst_req.aw.prot, 3'(id));
      assert (rot_q.size() > 0) else report_error("downstream AW without a port grant");
      if (rot_q.pop_front()) begin
        assert (p == (last_ds_port + 1) % num_ports)
          else report_value("mst_req_o.aw port", p, (last_ds_port + 1) % num_ports);
      end
      last_ds_port = p;
      if (early_w.size() > 0) begin
        check_w(id, early_w.pop_front());
      end else begin
        aw_ids.push_back(id);
      end
    end
    // W may overtake its AW downstream
    if (mst_req.w_valid && mst_rsp.w_ready) begin
      if (aw_ids.size() > 0) begin
        check_w(aw_ids.pop_front(), mst_req.w);
      end else begin
        early_w.push_back(mst_req.w);
      end
    end
    // Port side transfers
    for (int i = 0; i < num_ports; i++) begin
      if (slv_rsps[i].aw_ready) begin
        assert (slv_reqs[i].aw_valid) else report_error("aw_ready given to an idle port");
        aw_idx[i]++;
        rot_q.push_back(all_busy && granted_once);
        granted_once = 1'b1;
      end
      if (slv_rsps[i].w_ready && slv_reqs[i].w_valid) begin
        w_idx[i]++;
      end
    end
    busy_ports = 0;
    for (int i = 0; i < num_ports; i++) begin
      if (aw_idx[i] < port_ids[i].size()) begin
        busy_ports++;
      end
    end
    all_busy = (busy_ports == num_ports);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int cycles;
    lfsr_q       = 32'hf2595ec7;
    rst          = 1'b1;
    requests_on  = 1'b0;
    slv_reqs     = '0;
    mst_rsp      = '0;
    completed    = 0;
    all_busy     = 1'b0;
    granted_once = 1'b0;
    last_ds_port = 0;
    for (int i = 0; i < num_ports; i++) begin
      aw_idx[i] = 0;
      w_idx[i]  = 0;
      ds_idx[i] = 0;
    end
    for (int i = 0; i < num_writes; i++) begin
      done_cnt[i] = 0;
    end
    load_writes();
    repeat (16) @(posedge clk);
    #(drive_delay);
    rst = 1'b0;
    // A few idle cycles, then the ports start
    cycles = 0;
    while (completed < num_writes) begin
      assert (cycles < max_cycles) else report_error("timeout waiting for all writes");
      @(negedge clk);
      if (requests_on) begin
        sample_cycle();
      end else begin
        check_idle();
      end
      @(posedge clk);
      #(drive_delay);
      if (cycles == 3) begin
        requests_on = 1'b1;
      end
      drive_inputs();
      cycles++;
    end
    // Drain window for stray responses
    repeat (10) begin
      @(negedge clk);
      sample_cycle();
      @(posedge clk);
      #(drive_delay);
      drive_inputs();
    end
    assert (b_pend.size() == 0 && b_expect.size() == 0 && aw_ids.size() == 0)
      else report_error("responses left over at the end");
    for (int i = 0; i < num_writes; i++) begin
      assert (done_cnt[i] == 1) else report_value("completions of write", done_cnt[i], 1);
    end
    if (u_axi_lite_wr_mux.u_wr_mux_assertions.error_count == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("TESTS FAILED");
      $fatal(1, "Protocol assertion failed");
    end
  end

endmodule

// File: wr_mux_input.txt
// One write per line, all hex: port address data strobe response
// Address bits 31:30 equal the port
0 00001000 a5a50001 f 0
1 40002004 5a5a0002 3 0
2 80003008 c3c30003 c 2
3 c000400c 3c3c0004 f 0
0 00001010 11110005 1 1
1 40002014 22220006 f 0
2 80003018 33330007 6 0
3 c000401c 44440008 8 3
0 00001020 55550009 f 0
1 40002024 6666000a 2 2
2 80003028 7777000b f 0
3 c000402c 8888000c 9 0
0 00001030 9999000d 4 0
1 40002034 aaaa000e f 1
2 80003038 bbbb000f a 0
3 c000403c cccc0010 f 2
0 00001040 dddd0011 7 0
1 40002044 eeee0012 f 0
2 80003048 ffff0013 5 3
3 c000404c 01230014 f 0
0 00001050 45670015 b 2
1 40002054 89ab0016 f 0
2 80003058 cdef0017 e 0
3 c000405c fedc0018 f 1

// File: sim.f
+incdir+.
axi_lite_mux_pkg.sv
rr_arbiter.sv
sel_fifo.sv
spill_reg.sv
wr_route.sv
axi_lite_wr_mux.sv
tb_clock.sv
axi_lite_wr_mux_assertions.sv
axi_lite_wr_mux_tb.sv
